// ==== flist.f ====
logic/redmule_pkg.sv
logic/redmule_ctrl.sv
logic/redmule_scheduler.sv
logic/redmule_x_buffer.sv
logic/redmule_engine.sv
logic/redmule_top.sv
test/tb_redmule_mem.sv
test/tb_redmule_top.sv

// ==== logic/redmule_ctrl.sv ====
// Register file and job control
`timescale 1ns/100ps
`default_nettype none

module redmule_ctrl import redmule_pkg::*; (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        periph_req_i,
  input  reg_addr_t   periph_add_i,
  input  logic        periph_we_i,
  input  logic [31:0] periph_data_i,
  output logic        periph_gnt_o,
  output logic [31:0] periph_r_data_o,
  output logic        periph_r_valid_o,
  input  logic        done_i,
  output logic        start_o,
  output logic        accumulate_o,
  output addr_t       x_ptr_o,
  output addr_t       w_ptr_o,
  output addr_t       y_ptr_o,
  output addr_t       z_ptr_o,
  output logic        busy_o,
  output logic        evt_o
);

  logic        wr_en, rd_en, trigger;
  logic        busy_q, start_q, evt_q, acc_q, r_valid_q;
  addr_t       x_ptr_q, w_ptr_q, y_ptr_q, z_ptr_q;
  logic [31:0] rd_data, r_data_q;

  // Always ready for the host
  assign periph_gnt_o = periph_req_i;

  assign wr_en   = periph_req_i & periph_we_i;
  assign rd_en   = periph_req_i & ~periph_we_i;
  // Triggers while a job runs are dropped
  assign trigger = wr_en && (periph_add_i == REG_TRIGGER) && !busy_q;

  always_comb begin
    case (periph_add_i)
      REG_X_PTR:   rd_data = x_ptr_q;
      REG_W_PTR:   rd_data = w_ptr_q;
      REG_Y_PTR:   rd_data = y_ptr_q;
      REG_Z_PTR:   rd_data = z_ptr_q;
      REG_TRIGGER: rd_data = {31'b0, acc_q};
      REG_STATUS:  rd_data = {31'b0, busy_q};
      default:     rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      x_ptr_q   <= '0;
      w_ptr_q   <= '0;
      y_ptr_q   <= '0;
      z_ptr_q   <= '0;
      acc_q     <= 1'b0;
      busy_q    <= 1'b0;
      start_q   <= 1'b0;
      evt_q     <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      start_q   <= trigger;
      evt_q     <= done_i;
      r_valid_q <= rd_en;
      // Busy stays up through the event cycle
      if (evt_q) begin
        busy_q <= 1'b0;
      end
      if (trigger) begin
        busy_q <= 1'b1;
        acc_q  <= periph_data_i[0];
      end
      if (wr_en) begin
        case (periph_add_i)
          REG_X_PTR: x_ptr_q <= periph_data_i;
          REG_W_PTR: w_ptr_q <= periph_data_i;
          REG_Y_PTR: y_ptr_q <= periph_data_i;
          REG_Z_PTR: z_ptr_q <= periph_data_i;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      r_data_q <= rd_data;
    end
  end

  assign periph_r_data_o  = r_data_q;
  assign periph_r_valid_o = r_valid_q;
  assign start_o          = start_q;
  assign accumulate_o     = acc_q;
  assign x_ptr_o          = x_ptr_q;
  assign w_ptr_o          = w_ptr_q;
  assign y_ptr_o          = y_ptr_q;
  assign z_ptr_o          = z_ptr_q;
  assign busy_o           = busy_q;
  assign evt_o            = evt_q;

endmodule

`default_nettype wire

// ==== logic/redmule_engine.sv ====
// Integer MAC grid with Z readout
`timescale 1ns/100ps
`default_nettype none

module redmule_engine import redmule_pkg::*; (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    bias_load_i,
  input  step_t                   bias_row_i,
  input  logic                    acc_clear_i,
  input  logic                    mac_step_i,
  input  elem_t [ARRAY_WIDTH-1:0] x_col_i,
  input  row_t                    w_row_i,
  input  step_t                   z_row_sel_i,
  output row_t                    z_row_o
);

  elem_t [ARRAY_WIDTH-1:0][ARRAY_HEIGHT-1:0] acc_q, mac_d;
  elem_t [ARRAY_HEIGHT-1:0]                  w_elem;

  assign w_elem = w_row_i;

  // Products and sums wrap to the element width
  always_comb begin
    for (int r = 0; r < ARRAY_WIDTH; r++) begin
      for (int c = 0; c < ARRAY_HEIGHT; c++) begin
        mac_d[r][c] = acc_q[r][c] + x_col_i[r] * w_elem[c];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      acc_q <= '0;
    end else if (acc_clear_i) begin
      acc_q <= '0;
    end else if (bias_load_i) begin
      acc_q[bias_row_i] <= w_row_i;
    end else if (mac_step_i) begin
      acc_q <= mac_d;
    end
  end

  // Accumulator rows double as the Z buffer
  assign z_row_o = acc_q[z_row_sel_i];

endmodule

`default_nettype wire

// ==== logic/redmule_pkg.sv ====
// Matrix multiply accelerator
// Shared sizes, types and register map
`default_nettype none

package redmule_pkg;

  // Grid size, Z is ARRAY_WIDTH x ARRAY_HEIGHT and the depth equals the height
  localparam int unsigned ARRAY_WIDTH  = 4;
  localparam int unsigned ARRAY_HEIGHT = 4;
  localparam int unsigned ELEM_W       = 16;

  typedef logic [ELEM_W-1:0]              elem_t;
  // One matrix row per memory word, element 0 in the low bits
  typedef logic [ARRAY_HEIGHT*ELEM_W-1:0] row_t;
  typedef logic [31:0]                    addr_t;
  typedef logic [2:0]                     reg_addr_t;
  typedef logic [1:0]                     step_t;

  // Peripheral register map
  localparam reg_addr_t REG_X_PTR   = 3'd0;
  localparam reg_addr_t REG_W_PTR   = 3'd1;
  localparam reg_addr_t REG_Y_PTR   = 3'd2;
  localparam reg_addr_t REG_Z_PTR   = 3'd3;
  localparam reg_addr_t REG_TRIGGER = 3'd4;
  localparam reg_addr_t REG_STATUS  = 3'd5;

  typedef enum logic [2:0] {
    IDLE,
    LOAD_X,
    LOAD_Y,
    COMPUTE,
    STORE_Z,
    DONE
  } sched_state_e;

endpackage

`default_nettype wire

// ==== logic/redmule_scheduler.sv ====
// Job sequencer for loads, compute and stores
`timescale 1ns/100ps
`default_nettype none

module redmule_scheduler import redmule_pkg::*; (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  start_i,
  input  logic  accumulate_i,
  input  addr_t x_ptr_i,
  input  addr_t w_ptr_i,
  input  addr_t y_ptr_i,
  input  addr_t z_ptr_i,
  output logic  tcdm_req_o,
  output addr_t tcdm_add_o,
  output logic  tcdm_wen_o,
  output row_t  tcdm_data_o,
  input  logic  tcdm_gnt_i,
  input  logic  tcdm_r_valid_i,
  input  row_t  z_data_i,
  output logic  x_load_o,
  output step_t x_row_o,
  output step_t x_col_o,
  output logic  bias_load_o,
  output logic  acc_clear_o,
  output logic  mac_step_o,
  output step_t z_row_o,
  output logic  done_o
);

  sched_state_e state_q, state_d;
  step_t        cnt_q, cnt_d;
  logic         pending_q, pending_d;
  logic         last, rd_done, is_load;
  addr_t        base;

  // Depth of the compute phase is the W row count
  assign last    = (state_q == COMPUTE) ? (cnt_q == step_t'(ARRAY_HEIGHT - 1))
                                        : (cnt_q == step_t'(ARRAY_WIDTH - 1));
  assign rd_done = pending_q & tcdm_r_valid_i;
  assign is_load = (state_q == LOAD_X) || (state_q == LOAD_Y) || (state_q == COMPUTE);

  always_comb begin
    case (state_q)
      LOAD_X:  base = x_ptr_i;
      LOAD_Y:  base = y_ptr_i;
      COMPUTE: base = w_ptr_i;
      default: base = z_ptr_i;
    endcase
  end

  // One request at a time, held until grant
  assign tcdm_req_o  = (is_load && !pending_q) || (state_q == STORE_Z);
  assign tcdm_wen_o  = (state_q == STORE_Z);
  assign tcdm_add_o  = base + addr_t'(cnt_q);
  assign tcdm_data_o = z_data_i;

  always_comb begin
    state_d   = state_q;
    cnt_d     = cnt_q;
    pending_d = pending_q;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d   = LOAD_X;
          cnt_d     = '0;
          pending_d = 1'b0;
        end
      end
      LOAD_X, LOAD_Y, COMPUTE: begin
        if (tcdm_req_o && tcdm_gnt_i) begin
          pending_d = 1'b1;
        end
        if (rd_done) begin
          pending_d = 1'b0;
          cnt_d     = cnt_q + step_t'(1);
          if (last) begin
            case (state_q)
              LOAD_X:  state_d = accumulate_i ? LOAD_Y : COMPUTE;
              LOAD_Y:  state_d = COMPUTE;
              default: state_d = STORE_Z;
            endcase
          end
        end
      end
      STORE_Z: begin
        if (tcdm_gnt_i) begin
          cnt_d = cnt_q + step_t'(1);
          if (last) begin
            state_d = DONE;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= IDLE;
      cnt_q     <= '0;
      pending_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      cnt_q     <= cnt_d;
      pending_q <= pending_d;
    end
  end

  // Buffer and engine strobes fire with the returning read data
  assign x_load_o    = (state_q == LOAD_X) && rd_done;
  assign bias_load_o = (state_q == LOAD_Y) && rd_done;
  assign mac_step_o  = (state_q == COMPUTE) && rd_done;
  // Without accumulate the grid starts from zero
  assign acc_clear_o = (state_q == LOAD_X) && rd_done && last && !accumulate_i;

  assign x_row_o = cnt_q;
  assign x_col_o = cnt_q;
  assign z_row_o = cnt_q;
  assign done_o  = (state_q == DONE);

endmodule

`default_nettype wire

// ==== logic/redmule_top.sv ====
// Matrix multiply accelerator top level
`timescale 1ns/100ps
`default_nettype none

module redmule_top import redmule_pkg::*; (
  input  logic        clk_i,
  input  logic        arst_n_i,
  // Peripheral slave port
  input  logic        periph_req_i,
  input  reg_addr_t   periph_add_i,
  input  logic        periph_we_i,
  input  logic [31:0] periph_data_i,
  output logic        periph_gnt_o,
  output logic [31:0] periph_r_data_o,
  output logic        periph_r_valid_o,
  // Memory master port
  output logic        tcdm_req_o,
  output addr_t       tcdm_add_o,
  output logic        tcdm_wen_o,
  output row_t        tcdm_data_o,
  input  logic        tcdm_gnt_i,
  input  row_t        tcdm_r_data_i,
  input  logic        tcdm_r_valid_i,
  output logic        busy_o,
  output logic        evt_o
);

  logic  start, done, accumulate;
  addr_t x_ptr, w_ptr, y_ptr, z_ptr;

  logic  x_load;
  step_t x_row, x_col;
  elem_t [ARRAY_WIDTH-1:0] x_col_data;

  logic  bias_load, acc_clear, mac_step;
  step_t z_row;
  row_t  z_data;

  redmule_ctrl i_ctrl (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .periph_req_i     ( periph_req_i     ),
    .periph_add_i     ( periph_add_i     ),
    .periph_we_i      ( periph_we_i      ),
    .periph_data_i    ( periph_data_i    ),
    .periph_gnt_o     ( periph_gnt_o     ),
    .periph_r_data_o  ( periph_r_data_o  ),
    .periph_r_valid_o ( periph_r_valid_o ),
    .done_i           ( done             ),
    .start_o          ( start            ),
    .accumulate_o     ( accumulate       ),
    .x_ptr_o          ( x_ptr            ),
    .w_ptr_o          ( w_ptr            ),
    .y_ptr_o          ( y_ptr            ),
    .z_ptr_o          ( z_ptr            ),
    .busy_o           ( busy_o           ),
    .evt_o            ( evt_o            )
  );

  redmule_scheduler i_scheduler (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .start_i        ( start          ),
    .accumulate_i   ( accumulate     ),
    .x_ptr_i        ( x_ptr          ),
    .w_ptr_i        ( w_ptr          ),
    .y_ptr_i        ( y_ptr          ),
    .z_ptr_i        ( z_ptr          ),
    .tcdm_req_o     ( tcdm_req_o     ),
    .tcdm_add_o     ( tcdm_add_o     ),
    .tcdm_wen_o     ( tcdm_wen_o     ),
    .tcdm_data_o    ( tcdm_data_o    ),
    .tcdm_gnt_i     ( tcdm_gnt_i     ),
    .tcdm_r_valid_i ( tcdm_r_valid_i ),
    .z_data_i       ( z_data         ),
    .x_load_o       ( x_load         ),
    .x_row_o        ( x_row          ),
    .x_col_o        ( x_col          ),
    .bias_load_o    ( bias_load      ),
    .acc_clear_o    ( acc_clear      ),
    .mac_step_o     ( mac_step       ),
    .z_row_o        ( z_row          ),
    .done_o         ( done           )
  );

  redmule_x_buffer i_x_buffer (
    .clk_i      ( clk_i         ),
    .arst_n_i   ( arst_n_i      ),
    .load_i     ( x_load        ),
    .row_i      ( x_row         ),
    .col_i      ( x_col         ),
    .row_data_i ( tcdm_r_data_i ),
    .x_col_o    ( x_col_data    )
  );

  // Bias rows arrive on the same read bus as the W rows
  redmule_engine i_engine (
    .clk_i       ( clk_i         ),
    .arst_n_i    ( arst_n_i      ),
    .bias_load_i ( bias_load     ),
    .bias_row_i  ( x_row         ),
    .acc_clear_i ( acc_clear     ),
    .mac_step_i  ( mac_step      ),
    .x_col_i     ( x_col_data    ),
    .w_row_i     ( tcdm_r_data_i ),
    .z_row_sel_i ( z_row         ),
    .z_row_o     ( z_data        )
  );

endmodule

`default_nettype wire

// ==== logic/redmule_x_buffer.sv ====
// X operand buffer
`timescale 1ns/100ps
`default_nettype none

module redmule_x_buffer import redmule_pkg::*; (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    load_i,
  input  step_t                   row_i,
  input  step_t                   col_i,
  input  row_t                    row_data_i,
  output elem_t [ARRAY_WIDTH-1:0] x_col_o
);

  row_t [ARRAY_WIDTH-1:0] rows_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rows_q <= '0;
    end else if (load_i) begin
      rows_q[row_i] <= row_data_i;
    end
  end

  // Column k of X feeds step k, one element per engine row
  always_comb begin
    for (int r = 0; r < ARRAY_WIDTH; r++) begin
      x_col_o[r] = rows_q[r][col_i*ELEM_W +: ELEM_W];
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_redmule_mem.sv ====
// Row-wide memory model
`timescale 1ns/100ps
`default_nettype none

module tb_redmule_mem import redmule_pkg::*; #(
  parameter logic [31:0] SEED = 32'h62dd5c58
) (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  req_i,
  input  addr_t add_i,
  input  logic  wen_i,
  input  row_t  data_i,
  output logic  gnt_o,
  output row_t  r_data_o,
  output logic  r_valid_o
);

  row_t        mem [64];
  logic [31:0] rng = SEED;
  logic [1:0]  lat_q;
  logic        gnt_q, r_valid_q;
  row_t        r_data_q;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  assign gnt_o     = gnt_q;
  assign r_data_o  = r_data_q;
  assign r_valid_o = r_valid_q;

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gnt_q     <= 1'b0;
      lat_q     <= '0;
      r_valid_q <= 1'b0;
      r_data_q  <= '0;
    end else begin
      rng = lcg_next(rng);
      // Grant with a chance of three in four
      gnt_q     <= (rng[31:30] != 2'b00);
      r_valid_q <= (lat_q == 2'd1);
      if (lat_q != 2'd0) begin
        lat_q <= lat_q - 2'd1;
      end
      if (req_i && gnt_q) begin
        if (wen_i) begin
          mem[add_i[5:0]] <= data_i;
        end else begin
          r_data_q <= mem[add_i[5:0]];
          // Read data returns 1 to 3 cycles after grant
          lat_q    <= 2'd1 + 2'(rng[29:28] % 3);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_redmule_top.sv ====
// Testbench for the matrix multiply accelerator
`timescale 1ns/100ps
`default_nettype none

module tb_redmule_top import redmule_pkg::*; ();

  logic        clk, arst_n;
  logic        periph_req, periph_we, periph_gnt, periph_r_valid;
  reg_addr_t   periph_add;
  logic [31:0] periph_data, periph_r_data;
  logic        tcdm_req, tcdm_wen, tcdm_gnt, tcdm_r_valid;
  addr_t       tcdm_add;
  row_t        tcdm_data, tcdm_r_data;
  logic        busy, evt;

  int          errors, checks, evt_count;
  logic [31:0] rng;
  row_t        image [64];
  addr_t       x_base, w_base, y_base;
  // Memory port monitor state
  logic        outstanding, hold, hold_wen, evt_prev;
  addr_t       hold_add;
  row_t        hold_data;

  redmule_top i_dut (
    .clk_i            ( clk            ),
    .arst_n_i         ( arst_n         ),
    .periph_req_i     ( periph_req     ),
    .periph_add_i     ( periph_add     ),
    .periph_we_i      ( periph_we      ),
    .periph_data_i    ( periph_data    ),
    .periph_gnt_o     ( periph_gnt     ),
    .periph_r_data_o  ( periph_r_data  ),
    .periph_r_valid_o ( periph_r_valid ),
    .tcdm_req_o       ( tcdm_req       ),
    .tcdm_add_o       ( tcdm_add       ),
    .tcdm_wen_o       ( tcdm_wen       ),
    .tcdm_data_o      ( tcdm_data      ),
    .tcdm_gnt_i       ( tcdm_gnt       ),
    .tcdm_r_data_i    ( tcdm_r_data    ),
    .tcdm_r_valid_i   ( tcdm_r_valid   ),
    .busy_o           ( busy           ),
    .evt_o            ( evt            )
  );

  tb_redmule_mem i_mem (
    .clk_i     ( clk          ),
    .arst_n_i  ( arst_n       ),
    .req_i     ( tcdm_req     ),
    .add_i     ( tcdm_add     ),
    .wen_i     ( tcdm_wen     ),
    .data_i    ( tcdm_data    ),
    .gnt_o     ( tcdm_gnt     ),
    .r_data_o  ( tcdm_r_data  ),
    .r_valid_o ( tcdm_r_valid )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic reg_write(input reg_addr_t a, input logic [31:0] d);
    @(posedge clk);
    periph_req  <= 1'b1;
    periph_we   <= 1'b1;
    periph_add  <= a;
    periph_data <= d;
    @(posedge clk);
    periph_req <= 1'b0;
    periph_we  <= 1'b0;
  endtask

  task automatic reg_read(input reg_addr_t a, output logic [31:0] d);
    int waited;
    @(posedge clk);
    periph_req <= 1'b1;
    periph_we  <= 1'b0;
    periph_add <= a;
    @(posedge clk);
    periph_req <= 1'b0;
    waited = 1;
    @(posedge clk);
    while (!periph_r_valid && waited < 10) begin
      @(posedge clk);
      waited++;
    end
    d = periph_r_data;
    if (!periph_r_valid) begin
      errors++;
      $display("read of register %0d got no response", a);
    end else begin
      assert (waited == 1) else begin
        errors++;
        $display("read of register %0d answered %0d cycles after the request", a, waited);
      end
    end
  endtask

  task automatic fill_memory();
    row_t word;
    for (int a = 0; a < 64; a++) begin
      rng = lcg_next(rng);
      word[31:0] = rng;
      rng = lcg_next(rng);
      word[63:32] = rng;
      image[a] = word;
      i_mem.mem[a] <= word;
    end
  endtask

  // Z[r][c] = bias + sum over k of X[r][k] * W[k][c], wrapping at 16 bits
  function automatic elem_t ref_elem(input logic acc, input int r, input int c);
    elem_t sum;
    sum = acc ? image[y_base + r][c*ELEM_W +: ELEM_W] : elem_t'(0);
    for (int k = 0; k < 4; k++) begin
      sum = sum + image[x_base + r][k*ELEM_W +: ELEM_W] * image[w_base + k][c*ELEM_W +: ELEM_W];
    end
    return sum;
  endfunction

  task automatic run_job(input string name, input logic acc, input addr_t z_ptr,
                         input logic stray);
    logic [31:0] rd;
    int          waited;
    int          evt_before;
    row_t        z_word;
    reg_write(REG_X_PTR, x_base);
    reg_write(REG_W_PTR, w_base);
    reg_write(REG_Y_PTR, y_base);
    reg_write(REG_Z_PTR, z_ptr);
    evt_before = evt_count;
    reg_write(REG_TRIGGER, {31'b0, acc});
    @(posedge clk);
    check_value("busy_rise", 1, busy);
    reg_read(REG_STATUS, rd);
    check_value("status_busy", 1, rd);
    // A second trigger with the other flag must change nothing
    if (stray) begin
      reg_write(REG_TRIGGER, {31'b0, !acc});
    end
    waited = 0;
    while (!evt && waited < 500) begin
      @(posedge clk);
      waited++;
    end
    if (!evt) begin
      errors++;
      $display("job %s did not finish within 500 cycles", name);
    end else begin
      @(posedge clk);
      check_value("busy_after_evt", 0, busy);
    end
    repeat (10) @(posedge clk);
    check_value("evt_count", evt_before + 1, evt_count);
    reg_read(REG_STATUS, rd);
    check_value("status_idle", 0, rd);
    for (int r = 0; r < 4; r++) begin
      z_word = i_mem.mem[z_ptr + r];
      for (int c = 0; c < 4; c++) begin
        check_value(name, ref_elem(acc, r, c), z_word[c*ELEM_W +: ELEM_W]);
      end
    end
  endtask

  // Memory port protocol and event pulse checks
  always @(posedge clk) begin
    if (arst_n) begin
      // The peripheral port grants in the same cycle
      check_value("periph_gnt", periph_req, periph_gnt);
      if (evt) begin
        evt_count++;
        assert (busy) else begin
          errors++;
          $display("evt_o pulsed while busy_o was low");
        end
        assert (!evt_prev) else begin
          errors++;
          $display("evt_o stayed high for more than one cycle");
        end
      end
      if (tcdm_r_valid) begin
        outstanding = 1'b0;
      end
      if (tcdm_req) begin
        assert (!outstanding) else begin
          errors++;
          $display("memory request issued while a read was outstanding");
        end
        assert (tcdm_add < 64) else begin
          errors++;
          $display("memory address %0d is outside the memory model", tcdm_add);
        end
      end
      if (hold) begin
        assert (tcdm_req && tcdm_add == hold_add && tcdm_wen == hold_wen &&
                tcdm_data == hold_data) else begin
          errors++;
          $display("memory request changed before it was granted");
        end
      end
      hold      = tcdm_req && !tcdm_gnt;
      hold_add  = tcdm_add;
      hold_wen  = tcdm_wen;
      hold_data = tcdm_data;
      if (tcdm_req && tcdm_gnt && !tcdm_wen) begin
        outstanding = 1'b1;
      end
      evt_prev = evt;
    end
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] ptr_val [4];
    arst_n      = 1'b0;
    periph_req  = 1'b0;
    periph_we   = 1'b0;
    periph_add  = '0;
    periph_data = '0;
    errors      = 0;
    checks      = 0;
    evt_count   = 0;
    outstanding = 1'b0;
    hold        = 1'b0;
    evt_prev    = 1'b0;
    rng         = 32'h62dd5c58;
    x_base      = 32'd8;
    w_base      = 32'd16;
    y_base      = 32'd24;
    fill_memory();
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    check_value("reset_busy", 0, busy);
    check_value("reset_evt", 0, evt);
    for (int i = 0; i < 4; i++) begin
      reg_read(reg_addr_t'(i), rd);
      check_value("reset_ptr", 0, rd);
    end
    for (int i = 0; i < 4; i++) begin
      rng = lcg_next(rng);
      ptr_val[i] = rng;
      reg_write(reg_addr_t'(i), rng);
    end
    for (int i = 0; i < 4; i++) begin
      reg_read(reg_addr_t'(i), rd);
      check_value("ptr_readback", ptr_val[i], rd);
    end
    run_job("z_bias", 1'b1, 32'd32, 1'b1);
    run_job("z_no_bias", 1'b0, 32'd40, 1'b0);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
